/* src/timer_pkg.sv */
package timer_pkg;

	// ========================================================================
	// widths
	// ========================================================================
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;
	localparam int ADR_W = 6;
	localparam int IDX_W = 4;
	localparam int NUM_CH = 4;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [IDX_W-1:0] reg_idx_t;

	// ========================================================================
	// register map, word index taken from address bits 5..2
	// ========================================================================
	localparam reg_idx_t IDX_CONTROL = 4'd0;
	localparam reg_idx_t IDX_STATUS = 4'd1;
	localparam reg_idx_t IDX_CMP_BASE = 4'd4;
	localparam reg_idx_t IDX_CNT_BASE = 4'd8;
	localparam reg_idx_t IDX_COUNTER = 4'd12;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_BUSY,
		BUS_DONE
	} bus_state_t;

	// replace the selected byte lanes of old_word with those of new_word
	function automatic data_t byte_merge(input data_t old_word, input data_t new_word,
		input sel_t sel);
		data_t merged;
		merged = old_word;
		for (int b = 0; b < SEL_W; b++)
		begin
			if (sel[b])
				merged[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return merged;
	endfunction

endpackage

/* src/wb_bus_if.sv */
`timescale 1ns/1ps

module wb_bus_if (
	input  logic                           clk_i,
	input  logic                           rst_i,

	input  logic                           cyc_i,
	input  logic                           stb_i,
	input  logic                           we_i,
	input  logic [timer_pkg::ADR_W-1:0]    adr_i,
	input  timer_pkg::sel_t                sel_i,
	input  timer_pkg::data_t               dat_i,
	output timer_pkg::data_t               dat_o,
	output logic                           ack_o,
	output logic                           stall_o,

	input  timer_pkg::data_t               regs_rdata_i,
	input  timer_pkg::data_t               evt_rdata_i,
	output timer_pkg::reg_idx_t            reg_idx_o,
	output logic                           wr_en_o,
	output timer_pkg::data_t               wr_data_o,
	output timer_pkg::sel_t                wr_sel_o
);

	timer_pkg::bus_state_t state_q;
	timer_pkg::bus_state_t state_d;
	timer_pkg::data_t rdata_q;
	logic busy;

	// ========================================================================
	// access state machine
	// ========================================================================
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			timer_pkg::BUS_IDLE:
			begin
				if (cyc_i && stb_i)
					state_d = timer_pkg::BUS_BUSY;
			end
			timer_pkg::BUS_BUSY:
			begin
				state_d = timer_pkg::BUS_DONE;
			end
			timer_pkg::BUS_DONE:
			begin
				state_d = timer_pkg::BUS_IDLE;
			end
			default:
			begin
				state_d = timer_pkg::BUS_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			state_q <= timer_pkg::BUS_IDLE;
		else
			state_q <= state_d;
	end

	assign busy = (state_q == timer_pkg::BUS_BUSY);

	// ========================================================================
	// decode and write strobe
	// ========================================================================
	// the address is held stable by the master for the whole access,
	// so the index can be taken straight from it
	assign reg_idx_o = adr_i[5:2];
	assign wr_en_o = busy && we_i;
	assign wr_data_o = dat_i;
	assign wr_sel_o = sel_i;

	// only the owner of an index returns non-zero data, so OR is enough
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			rdata_q <= '0;
		else if (busy && !we_i)
			rdata_q <= regs_rdata_i | evt_rdata_i;
	end

	assign dat_o = rdata_q;
	assign ack_o = (state_q == timer_pkg::BUS_DONE);
	assign stall_o = 1'b0;

endmodule

/* src/timer_regs.sv */
`timescale 1ns/1ps

module timer_regs (
	input  logic                              clk_i,
	input  logic                              rst_i,

	input  timer_pkg::reg_idx_t               reg_idx_i,
	input  logic                              wr_en_i,
	input  timer_pkg::data_t                  wr_data_i,
	input  timer_pkg::sel_t                   wr_sel_i,
	output timer_pkg::data_t                  rdata_o,

	output logic [timer_pkg::NUM_CH-1:0]      ch_enable_o,
	output logic [timer_pkg::NUM_CH-1:0]      irq_enable_o,
	output timer_pkg::data_t                  cmp0_o,
	output timer_pkg::data_t                  cmp1_o,
	output timer_pkg::data_t                  cmp2_o,
	output timer_pkg::data_t                  cmp3_o
);

	timer_pkg::data_t control_q;
	timer_pkg::data_t control_d;
	timer_pkg::data_t cmp_q [timer_pkg::NUM_CH];
	timer_pkg::data_t cmp_d [timer_pkg::NUM_CH];
	logic ctrl_hit;
	logic cmp_hit;
	logic [1:0] cmp_sel;

	// ========================================================================
	// address decode
	// ========================================================================
	assign ctrl_hit = (reg_idx_i == timer_pkg::IDX_CONTROL);
	assign cmp_hit = (reg_idx_i >= timer_pkg::IDX_CMP_BASE) &&
		(reg_idx_i < timer_pkg::IDX_CMP_BASE + timer_pkg::NUM_CH);

	// the compare block is aligned to four words, the low bits pick the channel
	assign cmp_sel = reg_idx_i[1:0];

	// ========================================================================
	// register update
	// ========================================================================
	always_comb
	begin
		control_d = control_q;
		for (int i = 0; i < timer_pkg::NUM_CH; i++)
			cmp_d[i] = cmp_q[i];

		if (wr_en_i && ctrl_hit)
			control_d = timer_pkg::byte_merge(control_q, wr_data_i, wr_sel_i);

		if (wr_en_i && cmp_hit)
			cmp_d[cmp_sel] = timer_pkg::byte_merge(cmp_q[cmp_sel], wr_data_i, wr_sel_i);
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			control_q <= '0;
			for (int i = 0; i < timer_pkg::NUM_CH; i++)
				cmp_q[i] <= '0;
		end
		else
		begin
			control_q <= control_d;
			for (int i = 0; i < timer_pkg::NUM_CH; i++)
				cmp_q[i] <= cmp_d[i];
		end
	end

	// ========================================================================
	// read return
	// ========================================================================
	always_comb
	begin
		rdata_o = '0;
		if (ctrl_hit)
			rdata_o = control_q;
		else if (cmp_hit)
			rdata_o = cmp_q[cmp_sel];
	end

	// control word layout: channel enables low, interrupt enables above them
	assign ch_enable_o = control_q[timer_pkg::NUM_CH-1:0];
	assign irq_enable_o = control_q[2*timer_pkg::NUM_CH-1:timer_pkg::NUM_CH];

	assign cmp0_o = cmp_q[0];
	assign cmp1_o = cmp_q[1];
	assign cmp2_o = cmp_q[2];
	assign cmp3_o = cmp_q[3];

endmodule

/* src/timer_events.sv */
`timescale 1ns/1ps

module timer_events (
	input  logic                              clk_i,
	input  logic                              rst_i,

	input  timer_pkg::reg_idx_t               reg_idx_i,
	input  logic                              wr_en_i,
	input  timer_pkg::data_t                  wr_data_i,
	input  timer_pkg::sel_t                   wr_sel_i,
	output timer_pkg::data_t                  rdata_o,

	input  logic [timer_pkg::NUM_CH-1:0]      ch_enable_i,
	input  logic [timer_pkg::NUM_CH-1:0]      irq_enable_i,
	input  timer_pkg::data_t                  cmp0_i,
	input  timer_pkg::data_t                  cmp1_i,
	input  timer_pkg::data_t                  cmp2_i,
	input  timer_pkg::data_t                  cmp3_i,

	output logic [timer_pkg::NUM_CH-1:0]      irq_o
);

	timer_pkg::data_t counter_q;
	timer_pkg::data_t cmp [timer_pkg::NUM_CH];
	timer_pkg::data_t cnt_q [timer_pkg::NUM_CH];
	timer_pkg::data_t cnt_d [timer_pkg::NUM_CH];
	logic [timer_pkg::NUM_CH-1:0] status_q;
	logic [timer_pkg::NUM_CH-1:0] status_d;
	logic [timer_pkg::NUM_CH-1:0] match;
	timer_pkg::data_t status_word;
	timer_pkg::data_t status_toggled;
	logic status_hit;
	logic cnt_hit;
	logic [1:0] cnt_sel;

	assign cmp[0] = cmp0_i;
	assign cmp[1] = cmp1_i;
	assign cmp[2] = cmp2_i;
	assign cmp[3] = cmp3_i;

	// ========================================================================
	// free-running counter and compare
	// ========================================================================
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			counter_q <= '0;
		else
			counter_q <= counter_q + 1'b1;
	end

	always_comb
	begin
		for (int i = 0; i < timer_pkg::NUM_CH; i++)
			match[i] = ch_enable_i[i] && (cmp[i] == counter_q);
	end

	// ========================================================================
	// status and event counts
	// ========================================================================
	assign status_hit = (reg_idx_i == timer_pkg::IDX_STATUS);
	assign cnt_hit = (reg_idx_i >= timer_pkg::IDX_CNT_BASE) &&
		(reg_idx_i < timer_pkg::IDX_CNT_BASE + timer_pkg::NUM_CH);
	assign cnt_sel = reg_idx_i[1:0];

	// writing a one flips the status bit, lanes without a select are kept
	assign status_word = timer_pkg::data_t'(status_q);
	assign status_toggled = timer_pkg::byte_merge(status_word, status_word ^ wr_data_i,
		wr_sel_i);

	always_comb
	begin
		status_d = status_q;
		for (int i = 0; i < timer_pkg::NUM_CH; i++)
			cnt_d[i] = cnt_q[i];

		if (wr_en_i && status_hit)
			status_d = status_toggled[timer_pkg::NUM_CH-1:0];

		if (wr_en_i && cnt_hit)
			cnt_d[cnt_sel] = timer_pkg::byte_merge(cnt_q[cnt_sel], wr_data_i, wr_sel_i);

		// a match overrides a write to the same channel in the same cycle
		for (int i = 0; i < timer_pkg::NUM_CH; i++)
		begin
			if (match[i])
			begin
				status_d[i] = 1'b1;
				cnt_d[i] = cnt_q[i] + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			status_q <= '0;
			for (int i = 0; i < timer_pkg::NUM_CH; i++)
				cnt_q[i] <= '0;
		end
		else
		begin
			status_q <= status_d;
			for (int i = 0; i < timer_pkg::NUM_CH; i++)
				cnt_q[i] <= cnt_d[i];
		end
	end

	// ========================================================================
	// read return and interrupt lines
	// ========================================================================
	always_comb
	begin
		rdata_o = '0;
		if (status_hit)
			rdata_o = status_word;
		else if (cnt_hit)
			rdata_o = cnt_q[cnt_sel];
		else if (reg_idx_i == timer_pkg::IDX_COUNTER)
			rdata_o = counter_q;
	end

	assign irq_o = status_q & irq_enable_i;

endmodule

/* src/timer_top.sv */
`timescale 1ns/1ps

module timer_top (
	input  logic                              clk_i,
	input  logic                              rst_i,

	input  logic                              cyc_i,
	input  logic                              stb_i,
	input  logic                              we_i,
	input  logic [timer_pkg::ADR_W-1:0]       adr_i,
	input  timer_pkg::sel_t                   sel_i,
	input  timer_pkg::data_t                  dat_i,
	output timer_pkg::data_t                  dat_o,
	output logic                              ack_o,
	output logic                              stall_o,

	output logic [timer_pkg::NUM_CH-1:0]      irq_o
);

	timer_pkg::reg_idx_t reg_idx;
	logic wr_en;
	timer_pkg::data_t wr_data;
	timer_pkg::sel_t wr_sel;
	timer_pkg::data_t regs_rdata;
	timer_pkg::data_t evt_rdata;
	logic [timer_pkg::NUM_CH-1:0] ch_enable;
	logic [timer_pkg::NUM_CH-1:0] irq_enable;
	timer_pkg::data_t cmp0;
	timer_pkg::data_t cmp1;
	timer_pkg::data_t cmp2;
	timer_pkg::data_t cmp3;

	wb_bus_if u_bus (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cyc_i        (cyc_i),
		.stb_i        (stb_i),
		.we_i         (we_i),
		.adr_i        (adr_i),
		.sel_i        (sel_i),
		.dat_i        (dat_i),
		.dat_o        (dat_o),
		.ack_o        (ack_o),
		.stall_o      (stall_o),
		.regs_rdata_i (regs_rdata),
		.evt_rdata_i  (evt_rdata),
		.reg_idx_o    (reg_idx),
		.wr_en_o      (wr_en),
		.wr_data_o    (wr_data),
		.wr_sel_o     (wr_sel)
	);

	timer_regs u_regs (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.reg_idx_i    (reg_idx),
		.wr_en_i      (wr_en),
		.wr_data_i    (wr_data),
		.wr_sel_i     (wr_sel),
		.rdata_o      (regs_rdata),
		.ch_enable_o  (ch_enable),
		.irq_enable_o (irq_enable),
		.cmp0_o       (cmp0),
		.cmp1_o       (cmp1),
		.cmp2_o       (cmp2),
		.cmp3_o       (cmp3)
	);

	timer_events u_events (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.reg_idx_i    (reg_idx),
		.wr_en_i      (wr_en),
		.wr_data_i    (wr_data),
		.wr_sel_i     (wr_sel),
		.rdata_o      (evt_rdata),
		.ch_enable_i  (ch_enable),
		.irq_enable_i (irq_enable),
		.cmp0_i       (cmp0),
		.cmp1_i       (cmp1),
		.cmp2_i       (cmp2),
		.cmp3_i       (cmp3),
		.irq_o        (irq_o)
	);

endmodule

/* testbench/tb_timer_checker.sv */
`timescale 1ns/1ps

module tb_timer_checker (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          cyc_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [timer_pkg::ADR_W-1:0]   adr_i,
	input  timer_pkg::sel_t               sel_i,
	input  timer_pkg::data_t              dat_i,
	input  timer_pkg::data_t              rdata_i,
	input  logic                          ack_i,
	input  logic                          stall_i,
	input  logic [3:0]                    irq_i,
	output timer_pkg::data_t              counter_o,
	output int                            errors_o
);

	timer_pkg::data_t ctrl_m;
	timer_pkg::data_t cmp_m [4];
	timer_pkg::data_t cnt_m [4];
	logic [3:0] status_m;
	timer_pkg::data_t counter_m;
	timer_pkg::bus_state_t phase;
	logic read_pending;
	timer_pkg::data_t exp_rdata;
	int errors = 0;

	function automatic timer_pkg::data_t merge_lanes(input timer_pkg::data_t old_w,
		input timer_pkg::data_t new_w, input timer_pkg::sel_t sel);
		timer_pkg::data_t mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic timer_pkg::data_t expected_read(input timer_pkg::reg_idx_t idx);
		case (idx)
			4'd0: return ctrl_m;
			4'd1: return {28'd0, status_m};
			4'd4, 4'd5, 4'd6, 4'd7: return cmp_m[idx[1:0]];
			4'd8, 4'd9, 4'd10, 4'd11: return cnt_m[idx[1:0]];
			4'd12: return counter_m;
			default: return '0;
		endcase
	endfunction

	// ========================================================================
	// reference model, stepped on every clock edge
	// ========================================================================
	always @(posedge clk_i or posedge rst_i)
	begin : model_step
		timer_pkg::reg_idx_t idx;
		logic [3:0] hit;
		if (rst_i)
		begin
			ctrl_m = '0;
			for (int i = 0; i < 4; i++)
			begin
				cmp_m[i] = '0;
				cnt_m[i] = '0;
			end
			status_m = '0;
			counter_m = '0;
			phase = timer_pkg::BUS_IDLE;
			read_pending = 1'b0;
			exp_rdata = '0;
		end
		else
		begin
			idx = adr_i[5:2];
			// matches see the registers as they stood before this edge
			for (int i = 0; i < 4; i++)
				hit[i] = ctrl_m[i] && (cmp_m[i] == counter_m);
			if (phase == timer_pkg::BUS_BUSY)
			begin
				read_pending = !we_i;
				if (!we_i)
					exp_rdata = expected_read(idx);
				else
				begin
					case (idx)
						4'd0: ctrl_m = merge_lanes(ctrl_m, dat_i, sel_i);
						4'd1: status_m = sel_i[0] ? status_m ^ dat_i[3:0] : status_m;
						4'd4, 4'd5, 4'd6, 4'd7:
							cmp_m[idx[1:0]] = merge_lanes(cmp_m[idx[1:0]], dat_i, sel_i);
						4'd8, 4'd9, 4'd10, 4'd11:
							cnt_m[idx[1:0]] = merge_lanes(cnt_m[idx[1:0]], dat_i, sel_i);
						default: ;
					endcase
				end
			end
			for (int i = 0; i < 4; i++)
			begin
				if (hit[i])
				begin
					status_m[i] = 1'b1;
					cnt_m[i] = cnt_m[i] + 1;
				end
			end
			counter_m = counter_m + 1;
			case (phase)
				timer_pkg::BUS_IDLE: phase = (cyc_i && stb_i) ? timer_pkg::BUS_BUSY : phase;
				timer_pkg::BUS_BUSY: phase = timer_pkg::BUS_DONE;
				default: phase = timer_pkg::BUS_IDLE;
			endcase
		end
	end

	// outputs are compared mid-cycle, away from the clock edge
	always @(negedge clk_i)
	begin
		if (!rst_i)
		begin
			if (ack_i !== (phase == timer_pkg::BUS_DONE))
			begin
				$display("Mismatch at %0t: ack_o is %b, expected %b", $time, ack_i,
					phase == timer_pkg::BUS_DONE);
				errors = errors + 1;
			end
			if (stall_i !== 1'b0)
			begin
				$display("Mismatch at %0t: stall_o is %b, expected 0", $time, stall_i);
				errors = errors + 1;
			end
			if (irq_i !== (status_m & ctrl_m[7:4]))
			begin
				$display("Mismatch at %0t: irq_o is %h, expected %h", $time, irq_i,
					status_m & ctrl_m[7:4]);
				errors = errors + 1;
			end
			if (phase == timer_pkg::BUS_DONE && read_pending && rdata_i !== exp_rdata)
			begin
				$display("Mismatch at %0t: read data is %h, expected %h", $time, rdata_i,
					exp_rdata);
				errors = errors + 1;
			end
		end
	end

	assign counter_o = counter_m;
	assign errors_o = errors;

endmodule

/* testbench/tb_timer_top.sv */
`timescale 1ns/1ps

module tb_timer_top;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int ACK_LIMIT = 16;
	// planned length of each test, about four cycles per bus access
	localparam int PLANNED_CYCLES = 16*4 + 80*4 + 30*4 + (20*4 + 100) + 30*4;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + PLANNED_CYCLES * 3 / 2 + 200;

	logic clk = 1'b0;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [timer_pkg::ADR_W-1:0] adr;
	timer_pkg::sel_t sel;
	timer_pkg::data_t dat_w;
	timer_pkg::data_t dat_r;
	logic ack;
	logic stall;
	logic [3:0] irq;
	timer_pkg::data_t chk_counter;
	int chk_errors;
	int bus_fails = 0;
	int err_mark = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	timer_top u_dut (
		.clk_i   (clk),
		.rst_i   (rst),
		.cyc_i   (cyc),
		.stb_i   (stb),
		.we_i    (we),
		.adr_i   (adr),
		.sel_i   (sel),
		.dat_i   (dat_w),
		.dat_o   (dat_r),
		.ack_o   (ack),
		.stall_o (stall),
		.irq_o   (irq)
	);

	tb_timer_checker u_chk (
		.clk_i     (clk),
		.rst_i     (rst),
		.cyc_i     (cyc),
		.stb_i     (stb),
		.we_i      (we),
		.adr_i     (adr),
		.sel_i     (sel),
		.dat_i     (dat_w),
		.rdata_i   (dat_r),
		.ack_i     (ack),
		.stall_i   (stall),
		.irq_i     (irq),
		.counter_o (chk_counter),
		.errors_o  (chk_errors)
	);

	task bus_access(input logic write, input timer_pkg::reg_idx_t idx,
		input timer_pkg::data_t wdata, input timer_pkg::sel_t wsel,
		output timer_pkg::data_t rdata);
		int waited;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = {idx, 2'b00};
		sel = wsel;
		dat_w = wdata;
		@(negedge clk);
		waited = 1;
		while (!ack && waited < ACK_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		rdata = dat_r;
		if (!ack)
		begin
			$display("no acknowledge from the DUT for an access to index %0d", idx);
			bus_fails++;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task bus_write(input timer_pkg::reg_idx_t idx, input timer_pkg::data_t data,
		input timer_pkg::sel_t wsel);
		timer_pkg::data_t unused;
		bus_access(1'b1, idx, data, wsel, unused);
	endtask

	task bus_read(input timer_pkg::reg_idx_t idx, output timer_pkg::data_t data);
		bus_access(1'b0, idx, '0, 4'hf, data);
	endtask

	// waits one edge so the checker has settled the last access
	task end_test(input string name);
		int now_errors;
		@(posedge clk);
		now_errors = chk_errors + bus_fails;
		if (now_errors == err_mark)
		begin
			$display("test %s: passed", name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, now_errors - err_mark);
			tests_failed++;
		end
		err_mark = now_errors;
	endtask

	initial
	begin : main
		timer_pkg::data_t rd;
		timer_pkg::data_t base;
		logic [31:0] seed_val;
		int k;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		sel = '0;
		dat_w = '0;
		seed_val = $urandom(32'h8caa5019);
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// ====================================================================
		// reset state, then plain register access
		// ====================================================================
		for (k = 0; k < 16; k++)
			bus_read(k, rd);
		end_test("reset state");

		repeat (40)
		begin
			k = $urandom % 5;
			k = (k == 0) ? 0 : k + 3;
			bus_write(k, $urandom, $urandom % 16);
			bus_read(k, rd);
		end
		end_test("control and compare registers");

		// interrupt enables on and channels off, so irq_o tracks the toggles
		bus_write(0, 32'h0000_00f0, 4'hf);
		repeat (6)
		begin
			bus_write(1, $urandom, $urandom % 16);
			bus_read(1, rd);
		end
		bus_write(1, 32'h0, 4'hf);
		for (k = 8; k < 12; k++)
		begin
			bus_write(k, $urandom, $urandom % 16);
			bus_read(k, rd);
		end
		bus_read(1, rd);
		bus_write(1, rd, 4'h1);
		end_test("status toggling and event counts");

		// ====================================================================
		// compare matches
		// ====================================================================
		base = chk_counter;
		for (k = 4; k < 8; k++)
			bus_write(k, base + 40 + ($urandom % 40), 4'hf);
		bus_write(0, {24'd0, 4'($urandom), 4'hf}, 4'hf);
		repeat (100) @(negedge clk);
		bus_read(1, rd);
		for (k = 8; k < 12; k++)
			bus_read(k, rd);
		bus_write(0, 32'h0000_00ff, 4'h1);
		bus_read(1, rd);
		bus_write(1, rd, 4'h1);
		bus_read(1, rd);
		bus_write(0, 32'h0, 4'hf);
		end_test("compare matches");

		for (k = 13; k < 16; k++)
		begin
			bus_read(k, rd);
			bus_write(k, $urandom, 4'hf);
			bus_read(k, rd);
		end
		bus_write(12, $urandom, 4'hf);
		for (k = 0; k < 13; k++)
			bus_read(k, rd);
		bus_read(12, rd);
		end_test("map edges and counter");

		@(posedge clk);
		$display("tests passed %0d, failed %0d, mismatches %0d, bus failures %0d",
			tests_passed, tests_failed, chk_errors, bus_fails);
		if (tests_failed == 0 && chk_errors == 0 && bus_fails == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the test sequence did not finish",
			WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* verilog.f */
src/timer_pkg.sv
src/wb_bus_if.sv
src/timer_regs.sv
src/timer_events.sv
src/timer_top.sv
testbench/tb_timer_checker.sv
testbench/tb_timer_top.sv

/* Bender.yml */
package:
  name: timer

dependencies: {}

sources:
  - src/timer_pkg.sv
  - src/wb_bus_if.sv
  - src/timer_regs.sv
  - src/timer_events.sv
  - src/timer_top.sv
  - target: test
    files:
      - testbench/tb_timer_checker.sv
      - testbench/tb_timer_top.sv
